/* Bender.yml */
package:
  name: sb_core

sources:
  - source/sb_pkg.sv
  - source/issue_if.sv
  - source/complete_if.sv
  - source/sb_reg_file.sv
  - source/sb_decode.sv
  - source/sb_execute.sv
  - source/sb_result.sv
  - source/sb_core_top.sv
  - target: test
    files:
      - verif/sb_core_tb.sv

/* sb_core.f */
source/sb_pkg.sv
source/issue_if.sv
source/complete_if.sv
source/sb_reg_file.sv
source/sb_decode.sv
source/sb_execute.sv
source/sb_result.sv
source/sb_core_top.sv
verif/sb_core_tb.sv

/* source/complete_if.sv */
`default_nettype none

interface complete_if #(
    parameter int DATA_W = 16
);
    import sb_pkg::*;

    logic              alu_valid;
    reg_idx_t          alu_rd;
    logic [DATA_W-1:0] alu_data;

    // Never valid in the same cycle as the ALU completion
    logic              mul_valid;
    reg_idx_t          mul_rd;
    logic [DATA_W-1:0] mul_data;

    modport execute (
        output alu_valid, alu_rd, alu_data,
        output mul_valid, mul_rd, mul_data
    );

    modport result (
        input  alu_valid, alu_rd, alu_data,
        input  mul_valid, mul_rd, mul_data
    );
endinterface

`default_nettype wire

/* source/issue_if.sv */
`default_nettype none

interface issue_if #(
    parameter int DATA_W = 16
);
    import sb_pkg::*;

    // One strobe per accepted instruction, NOP never appears here
    logic              valid;
    opcode_e           op;
    reg_idx_t          rd;
    logic [DATA_W-1:0] opr0;
    logic [DATA_W-1:0] opr1;

    // Multiply in flight that an ALU op issued now would collide with
    logic              mul_slot_busy;

    modport decode (
        output valid, op, rd, opr0, opr1,
        input  mul_slot_busy
    );

    modport execute (
        input  valid, op, rd, opr0, opr1,
        output mul_slot_busy
    );
endinterface

`default_nettype wire

/* source/sb_core_top.sv */
`default_nettype none

module sb_core_top #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     rst_n_i,

    input  logic                     instr_valid_i,
    input  sb_pkg::opcode_e          instr_op_i,
    input  sb_pkg::reg_idx_t         instr_rd_i,
    input  sb_pkg::reg_idx_t         instr_rs0_i,
    input  sb_pkg::reg_idx_t         instr_rs1_i,
    input  logic [sb_pkg::IMM_W-1:0] instr_imm_i,
    output logic                     stall_o,

    output logic                     wb_valid_o,
    output sb_pkg::reg_idx_t         wb_rd_o,
    output logic [DATA_W-1:0]        wb_data_o
);

    // Register file read and reserve
    sb_pkg::reg_idx_t  rs0;
    sb_pkg::reg_idx_t  rs1;
    sb_pkg::reg_idx_t  rd;
    logic              reserve;
    logic [DATA_W-1:0] opr0;
    logic [DATA_W-1:0] opr1;
    logic              reserved0;
    logic              reserved1;
    logic              reserved_rd;

    issue_if    #(.DATA_W(DATA_W)) issue_bus ();
    complete_if #(.DATA_W(DATA_W)) cmpl_bus ();

    sb_reg_file #(.DATA_W(DATA_W)) reg_file_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .rs0_i         (rs0),
        .rs1_i         (rs1),
        .rd_i          (rd),
        .reserve_i     (reserve),
        .opr0_o        (opr0),
        .opr1_o        (opr1),
        .reserved0_o   (reserved0),
        .reserved1_o   (reserved1),
        .reserved_rd_o (reserved_rd),
        .wb_i          (wb_valid_o),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o)
    );

    sb_decode #(.DATA_W(DATA_W)) decode_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_op_i    (instr_op_i),
        .instr_rd_i    (instr_rd_i),
        .instr_rs0_i   (instr_rs0_i),
        .instr_rs1_i   (instr_rs1_i),
        .instr_imm_i   (instr_imm_i),
        .stall_o       (stall_o),
        .rs0_o         (rs0),
        .rs1_o         (rs1),
        .rd_o          (rd),
        .reserve_o     (reserve),
        .opr0_i        (opr0),
        .opr1_i        (opr1),
        .reserved0_i   (reserved0),
        .reserved1_i   (reserved1),
        .reserved_rd_i (reserved_rd),
        .issue_o       (issue_bus.decode)
    );

    sb_execute #(.DATA_W(DATA_W)) execute_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_bus.execute),
        .cmpl_o  (cmpl_bus.execute)
    );

    sb_result #(.DATA_W(DATA_W)) result_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cmpl_i     (cmpl_bus.result),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* source/sb_decode.sv */
`default_nettype none

module sb_decode #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     rst_n_i,

    input  logic                     instr_valid_i,
    input  sb_pkg::opcode_e          instr_op_i,
    input  sb_pkg::reg_idx_t         instr_rd_i,
    input  sb_pkg::reg_idx_t         instr_rs0_i,
    input  sb_pkg::reg_idx_t         instr_rs1_i,
    input  logic [sb_pkg::IMM_W-1:0] instr_imm_i,
    output logic                     stall_o,

    // Register file side
    output sb_pkg::reg_idx_t         rs0_o,
    output sb_pkg::reg_idx_t         rs1_o,
    output sb_pkg::reg_idx_t         rd_o,
    output logic                     reserve_o,
    input  logic [DATA_W-1:0]        opr0_i,
    input  logic [DATA_W-1:0]        opr1_i,
    input  logic                     reserved0_i,
    input  logic                     reserved1_i,
    input  logic                     reserved_rd_i,

    issue_if.decode                  issue_o
);
    import sb_pkg::*;

    logic reads_src;
    logic writes_rd;
    logic uses_alu;
    logic src_hazard;
    logic dst_hazard;
    logic slot_hazard;

    // Opcode classes
    assign reads_src = instr_op_i inside {ADD, SUB, AND, OR, XOR, MUL};
    assign writes_rd = instr_op_i inside {LDI, ADD, SUB, AND, OR, XOR, MUL};
    assign uses_alu  = instr_op_i inside {LDI, ADD, SUB, AND, OR, XOR};

    assign rs0_o = instr_rs0_i;
    assign rs1_o = instr_rs1_i;
    assign rd_o  = instr_rd_i;

    assign src_hazard  = reads_src & (reserved0_i | reserved1_i);
    assign dst_hazard  = writes_rd & reserved_rd_i;
    // ALU result would land on the same cycle as a multiply
    assign slot_hazard = uses_alu & issue_o.mul_slot_busy;

    assign stall_o = instr_valid_i & (src_hazard | dst_hazard | slot_hazard);

    // Accepted and not a NOP, so rd is claimed now
    assign reserve_o = instr_valid_i & ~stall_o & writes_rd;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o.valid <= 1'b0;
        end else begin
            issue_o.valid <= reserve_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reserve_o) begin
            issue_o.op   <= instr_op_i;
            issue_o.rd   <= instr_rd_i;
            issue_o.opr1 <= opr1_i;
            if (instr_op_i == LDI) begin
                issue_o.opr0 <= {{(DATA_W-IMM_W){1'b0}}, instr_imm_i};
            end else begin
                issue_o.opr0 <= opr0_i;
            end
        end
    end

endmodule

`default_nettype wire

/* source/sb_execute.sv */
`default_nettype none

module sb_execute #(
    parameter int DATA_W = 16
) (
    input  logic        clk,
    input  logic        rst_n_i,

    issue_if.execute    issue_i,
    complete_if.execute cmpl_o
);
    import sb_pkg::*;

    // ------------------------------
    // ALU path, one cycle
    // ------------------------------

    logic [DATA_W-1:0] alu_res;

    always_comb begin
        case (issue_i.op)
            LDI:     alu_res = issue_i.opr0;
            ADD:     alu_res = issue_i.opr0 + issue_i.opr1;
            SUB:     alu_res = issue_i.opr0 - issue_i.opr1;
            AND:     alu_res = issue_i.opr0 & issue_i.opr1;
            OR:      alu_res = issue_i.opr0 | issue_i.opr1;
            XOR:     alu_res = issue_i.opr0 ^ issue_i.opr1;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmpl_o.alu_valid <= 1'b0;
        end else begin
            cmpl_o.alu_valid <= issue_i.valid && (issue_i.op != MUL);
        end
    end

    always_ff @(posedge clk) begin
        cmpl_o.alu_rd   <= issue_i.rd;
        cmpl_o.alu_data <= alu_res;
    end

    // ------------------------------
    // Multiply pipeline
    // ------------------------------

    logic [MUL_STAGES-1:0] mul_vld_q;
    reg_idx_t              mul_rd_q   [MUL_STAGES];
    logic [DATA_W-1:0]     mul_prod_q [MUL_STAGES];
    logic [DATA_W-1:0]     mul_prod;

    // Only the low DATA_W bits of the product are kept
    assign mul_prod = issue_i.opr0 * issue_i.opr1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_vld_q <= '0;
        end else begin
            mul_vld_q <= {mul_vld_q[MUL_STAGES-2:0], issue_i.valid && (issue_i.op == MUL)};
        end
    end

    always_ff @(posedge clk) begin
        mul_rd_q[0]   <= issue_i.rd;
        mul_prod_q[0] <= mul_prod;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_rd_q[s]   <= mul_rd_q[s-1];
            mul_prod_q[s] <= mul_prod_q[s-1];
        end
    end

    // An ALU op issued now would complete together with this entry
    assign issue_i.mul_slot_busy = mul_vld_q[0];

    assign cmpl_o.mul_valid = mul_vld_q[MUL_STAGES-1];
    assign cmpl_o.mul_rd    = mul_rd_q[MUL_STAGES-1];
    assign cmpl_o.mul_data  = mul_prod_q[MUL_STAGES-1];

endmodule

`default_nettype wire

/* source/sb_pkg.sv */
`default_nettype none

package sb_pkg;

    // ------------------------------
    // Register file geometry
    // ------------------------------

    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 16;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Width of the LDI immediate, zero extended to the data width
    localparam int IMM_W = 8;

    // Registered stages between multiply issue and its completion
    localparam int MUL_STAGES = 3;

    // ------------------------------
    // Opcodes
    // ------------------------------

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDI = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        AND = 4'd4,
        OR  = 4'd5,
        XOR = 4'd6,
        MUL = 4'd7
    } opcode_e;

endpackage

`default_nettype wire

/* source/sb_reg_file.sv */
`default_nettype none

module sb_reg_file #(
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // Read and reservation check
    input  sb_pkg::reg_idx_t     rs0_i,
    input  sb_pkg::reg_idx_t     rs1_i,
    input  sb_pkg::reg_idx_t     rd_i,
    input  logic                 reserve_i,
    output logic [DATA_W-1:0]    opr0_o,
    output logic [DATA_W-1:0]    opr1_o,
    output logic                 reserved0_o,
    output logic                 reserved1_o,
    output logic                 reserved_rd_o,

    // Writeback
    input  logic                 wb_i,
    input  sb_pkg::reg_idx_t     wb_rd_i,
    input  logic [DATA_W-1:0]    wb_data_i
);
    import sb_pkg::*;

    logic [DATA_W-1:0]   regs_q [NUM_REGS];
    logic [NUM_REGS-1:0] reserved_q;

    // One-hot write and reserve selects
    logic [NUM_REGS-1:0] wb_sel;
    logic [NUM_REGS-1:0] rsv_sel;

    // Index only used when its strobe is high
    always_comb begin
        wb_sel  = '0;
        rsv_sel = '0;
        if (wb_i) begin
            wb_sel[wb_rd_i] = 1'b1;
        end
        if (reserve_i) begin
            rsv_sel[rd_i] = 1'b1;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------

    for (genvar r = 0; r < NUM_REGS; r++) begin : g_reg
        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                regs_q[r] <= '0;
            end else if (wb_sel[r]) begin
                regs_q[r] <= wb_data_i;
            end
        end
    end

    // Writeback releases a register, issue claims it
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reserved_q <= '0;
        end else begin
            reserved_q <= (reserved_q & ~wb_sel) | rsv_sel;
        end
    end

    // ------------------------------
    // Combinational read
    // ------------------------------

    assign opr0_o = regs_q[rs0_i];
    assign opr1_o = regs_q[rs1_i];

    assign reserved0_o   = reserved_q[rs0_i];
    assign reserved1_o   = reserved_q[rs1_i];
    assign reserved_rd_o = reserved_q[rd_i];

endmodule

`default_nettype wire

/* source/sb_result.sv */
`default_nettype none

module sb_result #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_n_i,

    complete_if.result        cmpl_i,

    // Single writeback, shared by the register file and the core outputs
    output logic              wb_valid_o,
    output sb_pkg::reg_idx_t  wb_rd_o,
    output logic [DATA_W-1:0] wb_data_o
);

    // ------------------------------
    // Writeback register
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= cmpl_i.alu_valid | cmpl_i.mul_valid;
        end
    end

    // At most one completion per cycle, multiply checked first
    always_ff @(posedge clk) begin
        if (cmpl_i.mul_valid) begin
            wb_rd_o   <= cmpl_i.mul_rd;
            wb_data_o <= cmpl_i.mul_data;
        end else begin
            wb_rd_o   <= cmpl_i.alu_rd;
            wb_data_o <= cmpl_i.alu_data;
        end
    end

endmodule

`default_nettype wire

/* verif/sb_core_tb.sv */
`default_nettype none

module sb_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sb_pkg::*;

    localparam int DATA_W     = 16;
    localparam int CLK_PERIOD = 40;
    localparam int FIELDS     = 6;
    localparam int MAX_TESTS  = 64;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              instr_valid_i;
    opcode_e           instr_op_i;
    reg_idx_t          instr_rd_i;
    reg_idx_t          instr_rs0_i;
    reg_idx_t          instr_rs1_i;
    logic [IMM_W-1:0]  instr_imm_i;
    logic              stall_o;
    logic              wb_valid_o;
    reg_idx_t          wb_rd_o;
    logic [DATA_W-1:0] wb_data_o;

    // Six hex words per test in the order op, rd, rs0, rs1, imm, expected
    logic [15:0]       test_mem [FIELDS*MAX_TESTS];
    int                num_tests;
    int                timeout_limit = 0;
    int                cycle_cnt = 0;
    logic [31:0]       rng_state;

    // Reference model of outstanding writes
    logic              pending  [NUM_REGS];
    logic [DATA_W-1:0] pend_val [NUM_REGS];
    int                pend_due [NUM_REGS];
    int                mul_issue_q [$];

    sb_core_top #(.DATA_W(DATA_W)) dut_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            report_error($sformatf("Timeout: run did not finish within %0d cycles",
                                   timeout_limit));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // Model
    // ------------------------------

    // Stall rule evaluated from the model's outstanding set
    function automatic logic predict_stall(input logic slot_busy);
        logic src_use;
        logic dst_use;
        logic alu_use;
        src_use = instr_op_i >= ADD;
        dst_use = instr_op_i != NOP;
        alu_use = dst_use && instr_op_i != MUL;
        return instr_valid_i && ((src_use && (pending[instr_rs0_i] || pending[instr_rs1_i]))
                                 || (dst_use && pending[instr_rd_i])
                                 || (alu_use && slot_busy));
    endfunction

    // Second multiplier stage is full when a MUL was accepted one edge ago
    function automatic logic mul_in_stage_two();
        foreach (mul_issue_q[j]) begin
            if (mul_issue_q[j] == cycle_cnt - 1) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int outstanding();
        int n = 0;
        foreach (pending[r]) n += pending[r];
        return n;
    endfunction

    task automatic present_instr(input int i);
        instr_valid_i = 1'b1;
        instr_op_i    = opcode_e'(test_mem[FIELDS*i][3:0]);
        instr_rd_i    = test_mem[FIELDS*i+1][3:0];
        instr_rs0_i   = test_mem[FIELDS*i+2][3:0];
        instr_rs1_i   = test_mem[FIELDS*i+3][3:0];
        instr_imm_i   = test_mem[FIELDS*i+4][IMM_W-1:0];
    endtask

    // Acceptance happens on the coming rising edge, cycle_cnt + 1
    task automatic record_accept(input int i);
        if (instr_op_i == MUL) mul_issue_q.push_back(cycle_cnt + 1);
        if (instr_op_i != NOP) begin
            pending[instr_rd_i]  = 1'b1;
            pend_val[instr_rd_i] = test_mem[FIELDS*i+5][DATA_W-1:0];
            pend_due[instr_rd_i] = cycle_cnt + 1 + ((instr_op_i == MUL) ? MUL_STAGES + 1 : 2);
        end
    endtask

    task automatic check_writeback(output int wb_reg);
        wb_reg = -1;
        foreach (pending[r]) begin
            if (pending[r] && pend_due[r] == cycle_cnt) begin
                wb_reg = r;
            end
        end
        if (wb_reg >= 0) begin
            assert (wb_valid_o === 1'b1 && wb_rd_o === reg_idx_t'(wb_reg)
                    && wb_data_o === pend_val[wb_reg])
                else report_error($sformatf("MISMATCH at %0t: wb %b r%0d %h, expected r%0d %h",
                    $time, wb_valid_o, wb_rd_o, wb_data_o, wb_reg, pend_val[wb_reg]));
        end else begin
            assert (wb_valid_o === 1'b0)
                else report_error($sformatf("MISMATCH at %0t: unexpected writeback to r%0d",
                                            $time, wb_rd_o));
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int   idx;
        int   wb_reg;
        logic exp_stall;
        logic presenting;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i    = NOP;
        instr_rd_i    = '0;
        instr_rs0_i   = '0;
        instr_rs1_i   = '0;
        instr_imm_i   = '0;
        rng_state     = 32'd57626;
        foreach (pending[r]) pending[r] = 1'b0;

        $readmemh("verif/sb_core_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && !$isunknown(test_mem[FIELDS*num_tests])) num_tests++;
        assert (num_tests > 0) else report_error("No tests found in verif/sb_core_tests.txt");
        timeout_limit = num_tests * 10 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        #(CLK_PERIOD/4);
        assert (wb_valid_o === 1'b0 && stall_o === 1'b0)
            else report_error($sformatf("MISMATCH at %0t: wb_valid_o %b stall_o %b after reset",
                                        $time, wb_valid_o, stall_o));

        idx = 0;
        presenting = 1'b0;
        while (idx < num_tests || outstanding() != 0) begin
            @(negedge clk);
            check_writeback(wb_reg);
            // A stalled instruction is held, otherwise maybe leave an idle gap
            if (!presenting) begin
                rng_state = xorshift32(rng_state);
                if (idx < num_tests && rng_state[1:0] != 2'b00) begin
                    present_instr(idx);
                    presenting = 1'b1;
                end else begin
                    instr_valid_i = 1'b0;
                end
            end
            #(CLK_PERIOD/4);
            exp_stall = predict_stall(mul_in_stage_two());
            assert (stall_o === exp_stall)
                else report_error($sformatf(
                    "MISMATCH at %0t: stall_o %b, expected %b for test %0d",
                    $time, stall_o, exp_stall, idx));
            // Reservation of the written register drops on the coming edge
            if (wb_reg >= 0) pending[wb_reg] = 1'b0;
            if (instr_valid_i && !exp_stall) begin
                record_accept(idx);
                idx++;
                presenting = 1'b0;
            end
        end
        instr_valid_i = 1'b0;
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sb_core_tests.txt */
// op rd rs0 rs1 imm expected, all hex, one instruction per line
// op: 0 NOP, 1 LDI, 2 ADD, 3 SUB, 4 AND, 5 OR, 6 XOR, 7 MUL
1 1 0 0 05 0005
1 2 0 0 03 0003
1 3 0 0 FF 00FF
2 4 1 2 00 0008
3 5 2 1 00 FFFE
4 6 3 1 00 0005
5 7 1 2 00 0007
6 8 3 2 00 00FC
7 9 3 3 00 FE01
2 A 1 1 00 000A
5 B 2 2 00 0003
2 C 9 1 00 FE06
7 D C C 00 E824
1 1 0 0 10 0010
7 E 1 2 00 0030
7 F 2 2 00 0009
6 0 E F 00 0039
0 0 0 0 00 0000
3 2 0 D 00 1815
1 3 0 0 80 0080
7 4 3 3 00 4000
7 5 4 3 00 0000
5 6 2 3 00 1895
2 7 7 7 00 000E
3 8 5 1 00 FFF0
1 9 0 0 AA 00AA
7 A 9 6 00 52F2
2 B A A 00 A5E4
6 C B 6 00 BD71
7 D C 8 00 28F0
0 3 3 3 00 0000
6 F D E 00 28C0
3 0 F C 00 6B4F
